//--- flist.f
design/rd_cvt_cfg_pkg.sv
design/rd_cvt_pkt_pkg.sv
design/rd_req_decode.sv
design/rd_os_throttle.sv
design/rd_ar_skid_pipe.sv
design/rd_ig_cvt.sv
test/rd_ig_cvt_checker.sv
test/tb_rd_ig_cvt.sv

//--- Makefile
# Verilator build and run of the read-command converter testbench

VERILATOR ?= verilator
TOP       ?= tb_rd_ig_cvt
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

# pass only if the run prints the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_rd_ig_cvt.sv
// ==========================================================
// testbench for the read-command converter: clock, reset,
// stimulus table with expected entries, LFSR stalls
// ==========================================================
`timescale 1ns/100ps

module tb_rd_ig_cvt;

  localparam int addr_width = 32;
  localparam int n_ent = 9;

  logic                   nvdla_core_clk;
  logic                   nvdla_core_rstn;
  logic                   spt2cvt_req_valid;
  logic                   spt2cvt_req_ready;
  logic [addr_width+10:0] spt2cvt_req_pd;
  logic                   cq_wr_pvld;
  logic                   cq_wr_prdy;
  logic [3:0]             cq_wr_thread_id;
  logic [6:0]             cq_wr_pd;
  logic                   cvif2noc_axi_ar_arvalid;
  logic                   cvif2noc_axi_ar_arready;
  logic [7:0]             cvif2noc_axi_ar_arid;
  logic [addr_width-1:0]  cvif2noc_axi_ar_araddr;
  logic [3:0]             cvif2noc_axi_ar_arlen;
  logic                   eg2ig_axi_vld;
  logic [7:0]             reg2dp_rd_os_cnt;
  logic [1:0]             exp_len;
  logic [6:0]             exp_cq;
  int                     val_errs;
  int                     proto_errs;
  int                     ar_pending;
  logic [31:0]            lfsr;
  int                     prdy_stall;
  int                     n_timeout;
  int                     n_early;

  // ==========================================================
  // stimulus table
  // ==========================================================
  // flags are {ftran, ltran, odd, swizzle}
  // entries 7 and 8 run into the limit and wait for returns
  logic [3:0]  tbl_axid [n_ent] = '{4'h1, 4'h2, 4'h3, 4'hf, 4'h4, 4'h5, 4'h6, 4'h7, 4'h8};
  logic [31:0] tbl_addr [n_ent] = '{32'h0000_1000, 32'h0000_2020, 32'h1234_5640,
                                    32'hffff_ff00, 32'h0000_00a0, 32'h0000_0040,
                                    32'h0000_0c80, 32'h0000_0d00, 32'h0000_0e20};
  logic [2:0]  tbl_size [n_ent] = '{3'd1, 3'd2, 3'd5, 3'd7, 3'd2, 3'd2, 3'd3, 3'd5, 3'd4};
  logic [3:0]  tbl_flag [n_ent] = '{4'b1101, 4'b1110, 4'b0101, 4'b0111, 4'b1101,
                                    4'b1100, 4'b0111, 4'b0000, 4'b1100};
  logic        tbl_hold [n_ent] = '{0, 0, 0, 0, 0, 0, 0, 1, 1};
  int          tbl_rets [n_ent] = '{2, 2, 3, 4, 0, 0, 0, 2, 3};
  // expected length and context entry {ldrop, fdrop, ltran, odd, swizzle, len}
  logic [1:0]  tbl_len  [n_ent] = '{2'd1, 2'd1, 2'd2, 2'd3, 2'd1, 2'd1, 2'd1, 2'd2, 2'd2};
  logic [6:0]  tbl_cq   [n_ent] = '{7'h15, 7'h39, 7'h16, 7'h1f, 7'h35, 7'h51, 7'h1d,
                                    7'h02, 7'h32};

  rd_ig_cvt #(.addr_width(addr_width)) DUT (.*);

  rd_ig_cvt_checker #(.addr_width(addr_width)) u_checker (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #2 nvdla_core_clk = ~nvdla_core_clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b = lfsr[0];
  endtask

  // next falling edge, new arready, queue ready only ever rises
  task automatic tick();
    logic b0;
    logic b1;
    @(negedge nvdla_core_clk);
    draw_bit(b0);
    draw_bit(b1);
    cvif2noc_axi_ar_arready = b0 | b1;
    if (prdy_stall > 0) prdy_stall--;
    cq_wr_prdy = (prdy_stall == 0);
  endtask

  task automatic present(input int i);
    logic b0;
    logic b1;
    tick();
    draw_bit(b0);
    draw_bit(b1);
    prdy_stall = {b1, b0};
    cq_wr_prdy = (prdy_stall == 0);
    spt2cvt_req_pd = {tbl_flag[i], tbl_size[i], tbl_addr[i], tbl_axid[i]};
    exp_len = tbl_len[i];
    exp_cq = tbl_cq[i];
    spt2cvt_req_valid = 1'b1;
  endtask

  task automatic wait_accept(input int limit, output logic ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < limit && !ok; n++) begin
      @(posedge nvdla_core_clk);
      if (spt2cvt_req_ready) ok = 1'b1;
      tick();
    end
  endtask

  task automatic send_returns(input int cnt);
    int n;
    for (n = 0; n < cnt; n++) begin
      eg2ig_axi_vld = 1'b1;
      tick();
    end
    eg2ig_axi_vld = 1'b0;
  endtask

  initial begin
    int   i;
    logic ok;
    nvdla_core_rstn = 1'b0;
    spt2cvt_req_valid = 1'b0;
    spt2cvt_req_pd = '0;
    cq_wr_prdy = 1'b1;
    cvif2noc_axi_ar_arready = 1'b1;
    eg2ig_axi_vld = 1'b0;
    reg2dp_rd_os_cnt = 8'd6;
    exp_len = '0;
    exp_cq = '0;
    lfsr = 32'h979fd9c7;
    prdy_stall = 0;
    n_timeout = 0;
    n_early = 0;
    repeat (4) @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    repeat (4) tick();

    for (i = 0; i < n_ent; i++) begin
      present(i);
      if (tbl_hold[i]) begin
        // must sit still until beats come back
        wait_accept(12, ok);
        if (ok) begin
          n_early++;
          $display("ERROR t=%0t request %0d accepted past the outstanding limit", $time, i);
        end else begin
          send_returns(tbl_rets[i]);
          wait_accept(60, ok);
          if (!ok) begin
            n_timeout++;
            $display("TIMEOUT t=%0t request %0d not released after returns", $time, i);
          end
        end
        spt2cvt_req_valid = 1'b0;
      end else begin
        wait_accept(60, ok);
        if (!ok) begin
          n_timeout++;
          $display("TIMEOUT t=%0t request %0d never accepted", $time, i);
        end
        spt2cvt_req_valid = 1'b0;
        send_returns(tbl_rets[i]);
      end
    end

    // drain the AR pipe
    for (i = 0; i < 100 && ar_pending != 0; i++) tick();
    if (ar_pending != 0) begin
      n_timeout++;
      $display("TIMEOUT t=%0t %0d AR commands never left the converter", $time, ar_pending);
    end
    repeat (2) tick();

    $display("errors: value %0d, protocol %0d, timeout %0d, limit %0d",
             val_errs, proto_errs, n_timeout, n_early);
    if (val_errs + proto_errs + n_timeout + n_early == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- test/rd_ig_cvt_checker.sv
// ==========================================================
// testbench checker for context entries, AR order and fields,
// the outstanding-beat model and the reset state
// ==========================================================
`timescale 1ns/100ps

module rd_ig_cvt_checker #(
  parameter int addr_width = 32
) (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic                   spt2cvt_req_valid,
  input  logic                   spt2cvt_req_ready,
  input  logic [addr_width+10:0] spt2cvt_req_pd,
  input  logic                   cq_wr_pvld,
  input  logic                   cq_wr_prdy,
  input  logic [3:0]             cq_wr_thread_id,
  input  logic [6:0]             cq_wr_pd,
  input  logic                   cvif2noc_axi_ar_arvalid,
  input  logic                   cvif2noc_axi_ar_arready,
  input  logic [7:0]             cvif2noc_axi_ar_arid,
  input  logic [addr_width-1:0]  cvif2noc_axi_ar_araddr,
  input  logic [3:0]             cvif2noc_axi_ar_arlen,
  input  logic                   eg2ig_axi_vld,
  input  logic [7:0]             reg2dp_rd_os_cnt,
  input  logic [1:0]             exp_len,
  input  logic [6:0]             exp_cq,
  output int                     val_errs,
  output int                     proto_errs,
  output int                     ar_pending
);

  // expected AR word holds id, address and length
  logic [addr_width+11:0] ar_q[$];
  logic [addr_width+11:0] ar_exp;
  logic [addr_width-1:0]  req_addr;
  int                     n_val = 0;
  int                     n_proto = 0;
  int                     os_model;
  logic                   ret_d;
  logic                   seen_req;
  logic                   ar_stalled;

  assign val_errs = n_val;
  assign proto_errs = n_proto;

  task automatic compare_field(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
    if (got !== exp) begin
      n_val++;
      $display("FAIL t=%0t %s exp=%0h got=%0h", $time, name, exp, got);
    end
  endtask

  always @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      os_model = 0;
      ret_d = 1'b0;
      seen_req = 1'b0;
      ar_stalled = 1'b0;
      ar_q.delete();
      ar_pending = 0;
    end else begin
      // quiet outputs until the first request shows up
      if (!seen_req && !spt2cvt_req_valid) begin
        compare_field("cvif2noc_axi_ar_arvalid", 0, cvif2noc_axi_ar_arvalid);
        compare_field("cq_wr_pvld", 0, cq_wr_pvld);
      end
      seen_req = seen_req | spt2cvt_req_valid;

      // ==========================================================
      // AR side
      // ==========================================================
      if (ar_stalled && !cvif2noc_axi_ar_arvalid) begin
        n_proto++;
        $display("ERROR t=%0t arvalid dropped while arready was low", $time);
      end
      ar_stalled = cvif2noc_axi_ar_arvalid & ~cvif2noc_axi_ar_arready;
      if (cvif2noc_axi_ar_arvalid && cvif2noc_axi_ar_arready) begin
        if (ar_q.size() == 0) begin
          n_proto++;
          $display("ERROR t=%0t AR transfer with no accepted request behind it", $time);
        end else begin
          ar_exp = ar_q.pop_front();
          compare_field("cvif2noc_axi_ar_arid", ar_exp[addr_width+11 -: 8], cvif2noc_axi_ar_arid);
          compare_field("cvif2noc_axi_ar_araddr", ar_exp[4 +: addr_width],
                        cvif2noc_axi_ar_araddr);
          compare_field("cvif2noc_axi_ar_arlen", ar_exp[3:0], cvif2noc_axi_ar_arlen);
        end
      end

      // ==========================================================
      // outstanding model and context entry
      // ==========================================================
      // returns land one cycle after the strobe
      os_model = os_model - int'(ret_d);
      ret_d = eg2ig_axi_vld;
      // the queue takes an entry on every pvld and prdy cycle
      if (cq_wr_pvld && cq_wr_prdy && !(spt2cvt_req_valid && spt2cvt_req_ready)) begin
        n_proto++;
        $display("ERROR t=%0t context entry written while no request was taken", $time);
      end
      if (spt2cvt_req_valid && spt2cvt_req_ready) begin
        req_addr = spt2cvt_req_pd[rd_cvt_pkt_pkg::req_addr_lsb +: addr_width];
        compare_field("cq_wr_pvld", 1, cq_wr_pvld);
        compare_field("cq_wr_pd", exp_cq, cq_wr_pd);
        compare_field("cq_wr_thread_id", spt2cvt_req_pd[3:0], cq_wr_thread_id);
        // AR address keeps 64-byte alignment only
        ar_q.push_back({4'h0, spt2cvt_req_pd[3:0], req_addr[addr_width-1:6], 6'h00,
                        2'b00, exp_len});
        os_model = os_model + int'(exp_len) + 1;
        if (os_model > int'(reg2dp_rd_os_cnt) + 1) begin
          n_proto++;
          $display("ERROR t=%0t outstanding beats %0d went past the limit %0d plus one",
                   $time, os_model, reg2dp_rd_os_cnt);
        end
      end
      ar_pending = ar_q.size();
    end
  end

endmodule

//--- design/rd_ig_cvt.sv
// ==========================================================
// ingress read-command converter top level
// ==========================================================
`timescale 1ns/100ps

module rd_ig_cvt #(
  parameter int addr_width = 32
) (
  input  logic                                      nvdla_core_clk,
  input  logic                                      nvdla_core_rstn,
  input  logic                                      spt2cvt_req_valid,
  output logic                                      spt2cvt_req_ready,
  input  logic [addr_width+10:0]                    spt2cvt_req_pd,
  output logic                                      cq_wr_pvld,
  input  logic                                      cq_wr_prdy,
  output logic [rd_cvt_cfg_pkg::axid_width-1:0]     cq_wr_thread_id,
  output logic [rd_cvt_pkt_pkg::cq_width-1:0]       cq_wr_pd,
  output logic                                      cvif2noc_axi_ar_arvalid,
  input  logic                                      cvif2noc_axi_ar_arready,
  output logic [rd_cvt_cfg_pkg::arid_width-1:0]     cvif2noc_axi_ar_arid,
  output logic [addr_width-1:0]                     cvif2noc_axi_ar_araddr,
  output logic [rd_cvt_cfg_pkg::arlen_width-1:0]    cvif2noc_axi_ar_arlen,
  input  logic                                      eg2ig_axi_vld,
  input  logic [rd_cvt_cfg_pkg::os_limit_width-1:0] reg2dp_rd_os_cnt
);

  localparam int idw = rd_cvt_cfg_pkg::axid_width;
  localparam int lw = rd_cvt_cfg_pkg::len_width;

  logic [lw-1:0]         cmd_len;
  logic [addr_width+5:0] cmd_word;
  logic                  axi_cmd_vld;
  logic                  axi_cmd_rdy;
  logic [addr_width+5:0] opipe_pd;

  rd_req_decode #(.addr_width(addr_width)) u_req_decode (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .req_pd          (spt2cvt_req_pd),
    .cmd_len         (cmd_len),
    .cmd_word        (cmd_word),
    .cq_pd           (cq_wr_pd),
    .cq_thread_id    (cq_wr_thread_id)
  );

  rd_os_throttle u_os_throttle (
    .nvdla_core_clk   (nvdla_core_clk),
    .nvdla_core_rstn  (nvdla_core_rstn),
    .req_valid        (spt2cvt_req_valid),
    .cq_wr_prdy       (cq_wr_prdy),
    .axi_cmd_rdy      (axi_cmd_rdy),
    .cmd_len          (cmd_len),
    .eg2ig_axi_vld    (eg2ig_axi_vld),
    .reg2dp_rd_os_cnt (reg2dp_rd_os_cnt),
    .req_ready        (spt2cvt_req_ready),
    .cq_wr_pvld       (cq_wr_pvld),
    .axi_cmd_vld      (axi_cmd_vld)
  );

  rd_ar_skid_pipe #(.addr_width(addr_width)) u_ar_skid_pipe (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_vld          (axi_cmd_vld),
    .in_pd           (cmd_word),
    .out_rdy         (cvif2noc_axi_ar_arready),
    .in_rdy          (axi_cmd_rdy),
    .out_vld         (cvif2noc_axi_ar_arvalid),
    .out_pd          (opipe_pd)
  );

  // ==========================================================
  // AR fields, id and length widened to the bus
  // ==========================================================
  assign cvif2noc_axi_ar_arid = {{(rd_cvt_cfg_pkg::arid_width-idw){1'b0}},
                                 opipe_pd[addr_width+lw +: idw]};
  assign cvif2noc_axi_ar_araddr = opipe_pd[lw +: addr_width];
  assign cvif2noc_axi_ar_arlen = {{(rd_cvt_cfg_pkg::arlen_width-lw){1'b0}},
                                  opipe_pd[lw-1:0]};

endmodule

//--- design/rd_ar_skid_pipe.sv
// ==========================================================
// one-stage skid buffer and pipe register for the AR word
// ==========================================================
`timescale 1ns/100ps

module rd_ar_skid_pipe #(
  parameter int addr_width = 32
) (
  input  logic                  nvdla_core_clk,
  input  logic                  nvdla_core_rstn,
  input  logic                  in_vld,
  input  logic [addr_width+5:0] in_pd,
  input  logic                  out_rdy,
  output logic                  in_rdy,
  output logic                  out_vld,
  output logic [addr_width+5:0] out_pd
);

  logic                  skid_catch;
  logic                  skid_ready;
  logic                  skid_valid;
  logic [addr_width+5:0] skid_data;
  logic                  sp_valid;
  logic [addr_width+5:0] sp_data;
  logic                  pipe_valid;
  logic                  pipe_ready_bc;
  logic [addr_width+5:0] pipe_data;

  // ==========================================================
  // skid stage
  // ==========================================================
  // ready was promised last cycle but the pipe is blocked
  assign skid_catch = in_vld & in_rdy & ~pipe_ready_bc;
  assign skid_ready = skid_valid ? pipe_ready_bc : ~skid_catch;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      skid_valid <= 1'b0;
      in_rdy <= 1'b1;
    end else begin
      skid_valid <= skid_valid ? ~pipe_ready_bc : skid_catch;
      // registered ready toward the throttle
      in_rdy <= skid_ready;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (skid_catch) begin
      skid_data <= in_pd;
    end
  end

  // bypass the skid while ready is up
  assign sp_valid = in_rdy ? in_vld : skid_valid;
  assign sp_data = in_rdy ? in_pd : skid_data;

  // ==========================================================
  // pipe stage
  // ==========================================================
  // an empty stage takes a word even if out_rdy is low
  assign pipe_ready_bc = out_rdy | ~pipe_valid;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pipe_valid <= 1'b0;
    end else begin
      pipe_valid <= pipe_ready_bc ? sp_valid : 1'b1;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (pipe_ready_bc && sp_valid) begin
      pipe_data <= sp_data;
    end
  end

  assign out_vld = pipe_valid;
  assign out_pd = pipe_data;

  // upstream keeps offering the word until the pipe takes it
  a_vld_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (in_vld && !in_rdy) |=> in_vld);

endmodule

//--- design/rd_os_throttle.sv
// ==========================================================
// outstanding-beat counter, full test and the
// request / context queue / AR pipe interlock
// ==========================================================
`timescale 1ns/100ps

module rd_os_throttle (
  input  logic                                      nvdla_core_clk,
  input  logic                                      nvdla_core_rstn,
  input  logic                                      req_valid,
  input  logic                                      cq_wr_prdy,
  input  logic                                      axi_cmd_rdy,
  input  logic [rd_cvt_cfg_pkg::len_width-1:0]      cmd_len,
  input  logic                                      eg2ig_axi_vld,
  input  logic [rd_cvt_cfg_pkg::os_limit_width-1:0] reg2dp_rd_os_cnt,
  output logic                                      req_ready,
  output logic                                      cq_wr_pvld,
  output logic                                      axi_cmd_vld
);

  localparam int cw = rd_cvt_cfg_pkg::os_cnt_width;
  localparam int lw = rd_cvt_cfg_pkg::len_width;
  localparam int mw = rd_cvt_cfg_pkg::os_limit_width;

  logic          eg_vld_d;
  logic [cw-1:0] os_cnt;
  logic [cw-1:0] os_cnt_nxt;
  logic [lw:0]   req_beats;
  logic [cw:0]   os_est;
  logic [cw:0]   os_lim;
  logic          os_full;
  logic          add_en;
  logic          sub_en;

  // ==========================================================
  // full test
  // ==========================================================
  // beats of the request on the port, len plus one
  assign req_beats = {1'b0, cmd_len} + 1'b1;

  // estimate of the count if this request went out now
  assign os_est = {1'b0, os_cnt}
                + (req_valid ? {{(cw+1-lw-1){1'b0}}, req_beats} : '0)
                - {{cw{1'b0}}, eg_vld_d};

  assign os_lim = {{(cw+1-mw){1'b0}}, reg2dp_rd_os_cnt} + 1'b1;
  assign os_full = os_est > os_lim;

  // ==========================================================
  // interlock
  // ==========================================================
  // each strobe waits on the other two sinks, never on itself
  assign cq_wr_pvld = req_valid & axi_cmd_rdy & ~os_full;
  assign axi_cmd_vld = req_valid & cq_wr_prdy & ~os_full;
  assign req_ready = axi_cmd_rdy & cq_wr_prdy & ~os_full;

  // ==========================================================
  // counter
  // ==========================================================
  assign add_en = axi_cmd_vld & axi_cmd_rdy;
  assign sub_en = eg_vld_d;

  assign os_cnt_nxt = os_cnt
                    + (add_en ? {{(cw-lw-1){1'b0}}, req_beats} : '0)
                    - {{(cw-1){1'b0}}, sub_en};

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      eg_vld_d <= 1'b0;
      os_cnt <= '0;
    end else begin
      // return strobe lands one cycle late
      eg_vld_d <= eg2ig_axi_vld;
      if (add_en || sub_en) begin
        os_cnt <= os_cnt_nxt;
      end
    end
  end

  // limit register tops out at 255, so 256 beats is the ceiling
  a_os_max: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (add_en || sub_en) |=> (os_cnt <= 9'd256));

endmodule

//--- design/rd_req_decode.sv
// ==========================================================
// request unpack, AR address and length calculation,
// context-entry packing
// ==========================================================
`timescale 1ns/100ps

module rd_req_decode #(
  parameter int addr_width = 32
) (
  input  logic                                     nvdla_core_clk,
  input  logic                                     nvdla_core_rstn,
  input  logic [addr_width+10:0]                   req_pd,
  output logic [rd_cvt_cfg_pkg::len_width-1:0]     cmd_len,
  output logic [addr_width+5:0]                    cmd_word,
  output logic [rd_cvt_pkt_pkg::cq_width-1:0]      cq_pd,
  output logic [rd_cvt_cfg_pkg::axid_width-1:0]    cq_thread_id
);

  // first bit above the address field
  localparam int flag_base = rd_cvt_pkt_pkg::req_addr_lsb + addr_width;
  localparam int clr_bits = rd_cvt_cfg_pkg::burst_lsb_clear;
  localparam int atom_lsb = rd_cvt_cfg_pkg::atom_lsb;

  logic [rd_cvt_cfg_pkg::axid_width-1:0] req_axid;
  logic [addr_width-1:0]                 req_addr;
  logic [rd_cvt_cfg_pkg::size_width-1:0] req_size;
  logic                                  req_swizzle;
  logic                                  req_odd;
  logic                                  req_ltran;
  logic                                  req_ftran;
  logic [2:0]                            stt_atom;
  logic [2:0]                            end_atom;
  logic                                  end_carry;
  logic [addr_width-1:0]                 ar_addr;
  logic                                  inc;
  logic                                  len_carry;
  logic                                  fdrop;
  logic                                  ldrop;

  // ==========================================================
  // unpack
  // ==========================================================
  assign req_axid = req_pd[rd_cvt_pkt_pkg::req_axid_lsb +: rd_cvt_cfg_pkg::axid_width];
  assign req_addr = req_pd[rd_cvt_pkt_pkg::req_addr_lsb +: addr_width];
  assign req_size =
    req_pd[flag_base + rd_cvt_pkt_pkg::req_size_ofs +: rd_cvt_cfg_pkg::size_width];
  assign req_swizzle = req_pd[flag_base + rd_cvt_pkt_pkg::req_swizzle_ofs];
  assign req_odd = req_pd[flag_base + rd_cvt_pkt_pkg::req_odd_ofs];
  assign req_ltran = req_pd[flag_base + rd_cvt_pkt_pkg::req_ltran_ofs];
  assign req_ftran = req_pd[flag_base + rd_cvt_pkt_pkg::req_ftran_ofs];

  // ==========================================================
  // address and length
  // ==========================================================
  // atom index within the 256-byte block
  assign stt_atom = req_addr[atom_lsb +: 3];
  assign {end_carry, end_atom} = {1'b0, stt_atom} + {1'b0, req_size};

  // AR address drops to 64-byte alignment
  assign ar_addr = {req_addr[addr_width-1:clr_bits], {clr_bits{1'b0}}};

  // single line, odd atom count, swizzled: one extra beat
  assign inc = req_ftran & req_ltran & req_size[0] & req_swizzle;
  assign {len_carry, cmd_len} = {1'b0, req_size[2:1]} + {2'b00, inc};

  // odd start means the lower half of the first beat is unused
  assign fdrop = req_ftran & stt_atom[0];
  // even end means the upper half of the last beat is unused
  assign ldrop = req_ltran & ~end_atom[0];

  // ==========================================================
  // outputs
  // ==========================================================
  // AR word for the pipe: id, address, length
  assign cmd_word = {req_axid, ar_addr, cmd_len};

  always_comb begin
    cq_pd = '0;
    cq_pd[rd_cvt_pkt_pkg::cq_lens_lsb +: rd_cvt_cfg_pkg::len_width] = cmd_len;
    cq_pd[rd_cvt_pkt_pkg::cq_swizzle_bit] = req_swizzle;
    cq_pd[rd_cvt_pkt_pkg::cq_odd_bit] = req_odd;
    cq_pd[rd_cvt_pkt_pkg::cq_ltran_bit] = req_ltran;
    cq_pd[rd_cvt_pkt_pkg::cq_fdrop_bit] = fdrop;
    cq_pd[rd_cvt_pkt_pkg::cq_ldrop_bit] = ldrop;
  end

  assign cq_thread_id = req_axid;

  // upstream splitter only issues 32-byte aligned requests
  a_addr_align: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    req_addr[4:0] == 5'd0);

  // splitter never lets a request cross a 256-byte block
  a_no_block_cross: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !end_carry);

  a_len_no_ovf: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !len_carry);

endmodule

//--- design/rd_cvt_pkt_pkg.sv
// ==========================================================
// field positions of the read request word
// and of the context entry sent to the egress side
// ==========================================================

package rd_cvt_pkt_pkg;

  // ==========================================================
  // request word
  // ==========================================================

  // thread id sits at the bottom
  parameter int req_axid_lsb = 0;

  // address follows the id
  parameter int req_addr_lsb = 4;

  // the flags sit above the address, so their positions
  // are given relative to the address top bit plus one

  // size field, 3 bits wide
  parameter int req_size_ofs = 0;

  // swizzle flag
  parameter int req_swizzle_ofs = 3;

  // odd flag
  parameter int req_odd_ofs = 4;

  // last transfer of a surface line
  parameter int req_ltran_ofs = 5;

  // first transfer of a surface line
  parameter int req_ftran_ofs = 6;

  // ==========================================================
  // context entry
  // ==========================================================

  // beats minus one
  parameter int cq_lens_lsb = 0;

  // flags passed through from the request
  parameter int cq_swizzle_bit = 2;
  parameter int cq_odd_bit = 3;
  parameter int cq_ltran_bit = 4;

  // drop the first or last 32-byte half of a beat
  parameter int cq_fdrop_bit = 5;
  parameter int cq_ldrop_bit = 6;

  // whole entry
  parameter int cq_width = 7;

endpackage

//--- design/rd_cvt_cfg_pkg.sv
// ==========================================================
// sizes used by the read-command converter
// id, length and counter widths, atom and burst offsets
// ==========================================================

package rd_cvt_cfg_pkg;

  // ==========================================================
  // id widths
  // ==========================================================

  // internal thread id carried by a request
  parameter int axid_width = 4;

  // id width on the external AR channel
  parameter int arid_width = 8;

  // ==========================================================
  // length and size fields
  // ==========================================================

  // internal burst length, beats minus one
  parameter int len_width = 2;

  // external AR length field
  parameter int arlen_width = 4;

  // request size in 32-byte atoms
  parameter int size_width = 3;

  // ==========================================================
  // outstanding-beat accounting
  // ==========================================================

  // counter holds up to 256 beats plus headroom
  parameter int os_cnt_width = 9;

  // programmed limit from the register file
  parameter int os_limit_width = 8;

  // ==========================================================
  // address geometry
  // ==========================================================

  // atom index inside a 256-byte block starts here
  parameter int atom_lsb = 5;

  // AR address is 64-byte aligned
  parameter int burst_lsb_clear = 6;

endpackage
